// File: src/icache_pkg.sv
// shared widths and sizes for the VIPT instruction cache
// imported by every RTL file that needs an address field or a derived width

package icache_pkg;

  // address fields
  localparam int page_offset_width = 12;
  localparam int ptag_width        = 20;
  localparam int byte_offset_width = 2;
  localparam int word_offset_width = 3;
  localparam int instr_width       = 32;
  localparam int paddr_width       = ptag_width + page_offset_width;
  localparam int block_offset_width = byte_offset_width + word_offset_width;

  // defaults handed down from the top level
  localparam int default_sets = 64;
  localparam int default_ways = 4;

  function automatic int index_width_f(input int sets);
    return (sets > 1) ? $clog2(sets) : 1;
  endfunction

  function automatic int way_width_f(input int ways);
    return (ways > 1) ? $clog2(ways) : 1;
  endfunction

  // stored tag covers every paddr bit above index and block offset
  function automatic int tag_width_f(input int sets);
    return paddr_width - block_offset_width - index_width_f(sets);
  endfunction

endpackage

// File: src/icache_array_if.sv
// array read path between the pipeline and the tag and data arrays
// request is driven in the fetch cycle, results arrive one cycle later

`timescale 1ns/100ps

interface icache_array_if
  import icache_pkg::*;
  #(parameter int sets_p = default_sets,
    parameter int ways_p = default_ways)
  ();

  localparam int index_w = index_width_f(sets_p);
  localparam int tag_w   = tag_width_f(sets_p);

  logic                                    rd_v;
  logic [index_w-1:0]                      rd_index;
  logic [word_offset_width-1:0]            rd_word;
  logic [ways_p-1:0][tag_w-1:0]            rd_tags;
  logic [ways_p-1:0]                       rd_valid;
  logic [ways_p-1:0][instr_width-1:0]      rd_words;

  modport pipeline (output rd_v, rd_index, rd_word, input rd_tags, rd_valid, rd_words);
  modport tag      (input rd_v, rd_index, output rd_tags, rd_valid);
  modport data     (input rd_v, rd_index, rd_word, output rd_words);

endinterface

// File: src/icache_tag_array.sv
// tag and valid storage, one entry per set and way
// read on rd_v, result held until the next lookup; fills set or invalidate a way

`timescale 1ns/100ps

module icache_tag_array
  import icache_pkg::*;
  #(parameter int sets_p = default_sets,
    parameter int ways_p = default_ways,
    localparam int index_w = index_width_f(sets_p),
    localparam int way_w   = way_width_f(ways_p),
    localparam int tag_w   = tag_width_f(sets_p))
  (input  logic               clk_i,
   input  logic               reset_i,
   icache_array_if.tag        arr,
   input  logic               tag_fill_v_i,
   input  logic [index_w-1:0] fill_index_i,
   input  logic [way_w-1:0]   fill_way_i,
   input  logic [tag_w-1:0]   fill_tag_i,
   input  logic               fill_valid_i,
   input  logic               fill_ready_i);

  logic [tag_w-1:0]  tag_mem [sets_p][ways_p];
  logic [ways_p-1:0] valid_r [sets_p];
  logic              fill_we;

  assign fill_we = tag_fill_v_i & fill_ready_i;

  // tags only change on a set, invalidate leaves the old tag behind
  always_ff @(posedge clk_i) begin
    if (fill_we && fill_valid_i) begin
      tag_mem[fill_index_i][fill_way_i] <= fill_tag_i;
    end
    if (arr.rd_v) begin
      for (int w = 0; w < ways_p; w++) begin
        arr.rd_tags[w] <= tag_mem[arr.rd_index][w];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        valid_r[s] <= '0;
      end
      arr.rd_valid <= '0;
    end else begin
      if (fill_we) begin
        valid_r[fill_index_i][fill_way_i] <= fill_valid_i;
      end
      if (arr.rd_v) begin
        arr.rd_valid <= valid_r[arr.rd_index];
      end
    end
  end

endmodule

// File: src/icache_data_array.sv
// instruction storage with one bank per way, whole blocks per bank
// a lookup reads the addressed word from every way, a fill writes one word

`timescale 1ns/100ps

module icache_data_array
  import icache_pkg::*;
  #(parameter int sets_p = default_sets,
    parameter int ways_p = default_ways,
    localparam int index_w = index_width_f(sets_p),
    localparam int way_w   = way_width_f(ways_p),
    localparam int words_p = sets_p * (2 ** word_offset_width))
  (input  logic                         clk_i,
   icache_array_if.data                 arr,
   input  logic                         data_fill_v_i,
   input  logic [index_w-1:0]           fill_index_i,
   input  logic [way_w-1:0]             fill_way_i,
   input  logic [word_offset_width-1:0] fill_word_i,
   input  logic [instr_width-1:0]       fill_data_i,
   input  logic                         fill_ready_i);

  logic [instr_width-1:0] bank_mem [ways_p][words_p];
  logic [index_w+word_offset_width-1:0] rd_addr;
  logic [index_w+word_offset_width-1:0] wr_addr;

  // bank address is {set, word}
  assign rd_addr = {arr.rd_index, arr.rd_word};
  assign wr_addr = {fill_index_i, fill_word_i};

  always_ff @(posedge clk_i) begin
    if (data_fill_v_i && fill_ready_i) begin
      bank_mem[fill_way_i][wr_addr] <= fill_data_i;
    end
    if (arr.rd_v) begin
      for (int w = 0; w < ways_p; w++) begin
        arr.rd_words[w] <= bank_mem[w][rd_addr];
      end
    end
  end

endmodule

// File: src/icache_plru.sv
// pseudo-LRU tree per set, heap ordered, updated on TV hits
// repl_way_o picks the lowest invalid way, else the tree's LRU leaf

`timescale 1ns/100ps

module icache_plru
  import icache_pkg::*;
  #(parameter int sets_p = default_sets,
    parameter int ways_p = default_ways,
    localparam int index_w = index_width_f(sets_p),
    localparam int way_w   = way_width_f(ways_p))
  (input  logic               clk_i,
   input  logic               reset_i,
   input  logic               update_i,
   input  logic [index_w-1:0] index_i,
   input  logic [way_w-1:0]   hit_way_i,
   input  logic [ways_p-1:0]  valid_bits_i,
   output logic [way_w-1:0]   repl_way_o);

  logic [ways_p-2:0] tree_r [sets_p];
  logic [ways_p-2:0] tree_cur;
  logic [ways_p-2:0] tree_upd;
  logic [way_w-1:0]  lru_way;
  logic [way_w-1:0]  inv_way;
  logic              inv_any;

  assign tree_cur = tree_r[index_i];

  // every node on the hit path points away from the hit way
  always_comb begin : hit_path
    int node;
    tree_upd = tree_cur;
    node = 0;
    for (int lvl = 0; lvl < way_w; lvl++) begin
      tree_upd[node] = ~hit_way_i[way_w-1-lvl];
      node = 2 * node + 1 + int'(hit_way_i[way_w-1-lvl]);
    end
  end

  // follow the bits from the root, msb of the way first
  always_comb begin : lru_walk
    int node;
    lru_way = '0;
    node = 0;
    for (int lvl = 0; lvl < way_w; lvl++) begin
      lru_way[way_w-1-lvl] = tree_cur[node];
      node = 2 * node + 1 + int'(tree_cur[node]);
    end
  end

  always_comb begin
    inv_way = '0;
    inv_any = 1'b0;
    for (int w = ways_p - 1; w >= 0; w--) begin
      if (!valid_bits_i[w]) begin
        inv_way = way_w'(w);
        inv_any = 1'b1;
      end
    end
  end

  assign repl_way_o = inv_any ? inv_way : lru_way;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        tree_r[s] <= '0;
      end
    end else if (update_i) begin
      tree_r[index_i] <= tree_upd;
    end
  end

endmodule

// File: src/icache_pipeline.sv
// TL/TV fetch pipeline: array lookup, tag compare, word select and miss handling
// result comes two cycles after a fetch is accepted; misses stall new fetches
// until the refill engine pulses complete

`timescale 1ns/100ps

module icache_pipeline
  import icache_pkg::*;
  #(parameter int sets_p = default_sets,
    parameter int ways_p = default_ways,
    localparam int index_w = index_width_f(sets_p),
    localparam int way_w   = way_width_f(ways_p),
    localparam int tag_w   = tag_width_f(sets_p))
  (input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic [page_offset_width-1:0] vaddr_i,
   input  logic                         vaddr_v_i,
   output logic                         vaddr_ready_o,
   input  logic [ptag_width-1:0]        ptag_i,
   input  logic                         ptag_v_i,
   input  logic                         poison_i,
   output logic [instr_width-1:0]       data_o,
   output logic                         data_v_o,
   output logic                         miss_o,
   input  logic                         cache_req_ready_i,
   input  logic                         cache_req_complete_i,
   output logic                         cache_req_v_o,
   output logic [paddr_width-1:0]       cache_req_addr_o,
   output logic                         cache_req_metadata_v_o,
   output logic [way_w-1:0]             cache_req_way_o,
   output logic                         fill_ready_o,
   input  logic [way_w-1:0]             repl_way_i,
   output logic                         plru_update_o,
   output logic [index_w-1:0]           tv_index_o,
   output logic [way_w-1:0]             hit_way_o,
   output logic [ways_p-1:0]            tv_valid_bits_o,
   icache_array_if.pipeline             arr);

  logic                                tl_we;
  logic                                tv_we;
  logic                                v_tl_r;
  logic [page_offset_width-1:0]        page_offset_tl_r;
  logic                                v_tv_r;
  logic [paddr_width-1:0]              paddr_tv_r;
  logic [ways_p-1:0][tag_w-1:0]        tags_tv_r;
  logic [ways_p-1:0]                   valid_tv_r;
  logic [ways_p-1:0][instr_width-1:0]  words_tv_r;
  logic [tag_w-1:0]                    tag_tv;
  logic [ways_p-1:0]                   hit_v;
  logic [way_w-1:0]                    hit_way;
  logic                                hit;
  logic                                miss_tv;
  logic                                miss_pending_r;
  logic                                metadata_v_r;
  logic [way_w-1:0]                    repl_way_r;

  assign tl_we = vaddr_v_i & vaddr_ready_o;

  // lookup goes straight to the arrays from the virtual offset
  assign arr.rd_v     = tl_we;
  assign arr.rd_index = vaddr_i[block_offset_width +: index_w];
  assign arr.rd_word  = vaddr_i[byte_offset_width +: word_offset_width];

  // arrays are busy with the lookup in an accept cycle
  assign fill_ready_o = ~tl_we;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
    end else begin
      v_tl_r <= tl_we;
    end
    if (tl_we) begin
      page_offset_tl_r <= vaddr_i;
    end
  end

  // TL item dies without a tag or when poisoned
  assign tv_we = v_tl_r & ptag_v_i & ~poison_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tv_r <= 1'b0;
    end else begin
      v_tv_r <= tv_we;
    end
    if (tv_we) begin
      paddr_tv_r <= {ptag_i, page_offset_tl_r};
      tags_tv_r  <= arr.rd_tags;
      valid_tv_r <= arr.rd_valid;
      words_tv_r <= arr.rd_words;
    end
  end

  assign tag_tv = paddr_tv_r[paddr_width-1 -: tag_w];

  always_comb begin
    for (int w = 0; w < ways_p; w++) begin
      hit_v[w] = valid_tv_r[w] && (tags_tv_r[w] == tag_tv);
    end
  end

  // lowest matching way wins
  always_comb begin
    hit_way = '0;
    for (int w = ways_p - 1; w >= 0; w--) begin
      if (hit_v[w]) begin
        hit_way = way_w'(w);
      end
    end
  end

  assign hit     = |hit_v;
  assign miss_tv = v_tv_r & ~hit;

  assign data_o   = words_tv_r[hit_way];
  assign data_v_o = v_tv_r & hit;
  assign miss_o   = miss_tv;

  assign cache_req_v_o    = miss_tv & cache_req_ready_i;
  assign cache_req_addr_o = {paddr_tv_r[paddr_width-1:block_offset_width],
                             {block_offset_width{1'b0}}};

  // metadata trails the request by one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      metadata_v_r   <= 1'b0;
      miss_pending_r <= 1'b0;
    end else begin
      metadata_v_r <= cache_req_v_o;
      if (cache_req_v_o) begin
        miss_pending_r <= 1'b1;
      end else if (cache_req_complete_i) begin
        miss_pending_r <= 1'b0;
      end
    end
    if (cache_req_v_o) begin
      repl_way_r <= repl_way_i;
    end
  end

  assign cache_req_metadata_v_o = metadata_v_r;
  assign cache_req_way_o        = repl_way_r;

  assign vaddr_ready_o = cache_req_ready_i & ~(cache_req_v_o | miss_pending_r);

  // replacement state sees TV hits only
  assign plru_update_o   = data_v_o;
  assign tv_index_o      = paddr_tv_r[block_offset_width +: index_w];
  assign hit_way_o       = hit_way;
  assign tv_valid_bits_o = valid_tv_r;

endmodule

// File: src/icache_top.sv
// top level of the VIPT instruction cache
// fetch, miss request and refill packets are plain ports; sets_p and ways_p
// are set here and passed down to every block

`timescale 1ns/100ps

module icache_top
  import icache_pkg::*;
  #(parameter int sets_p = default_sets,
    parameter int ways_p = default_ways,
    localparam int index_w = index_width_f(sets_p),
    localparam int way_w   = way_width_f(ways_p),
    localparam int tag_w   = tag_width_f(sets_p))
  (input  logic                         clk_i,
   input  logic                         reset_i,
   input  logic [page_offset_width-1:0] vaddr_i,
   input  logic                         vaddr_v_i,
   output logic                         vaddr_ready_o,
   input  logic [ptag_width-1:0]        ptag_i,
   input  logic                         ptag_v_i,
   input  logic                         poison_i,
   output logic [instr_width-1:0]       data_o,
   output logic                         data_v_o,
   output logic                         miss_o,
   input  logic                         cache_req_ready_i,
   output logic                         cache_req_v_o,
   output logic [paddr_width-1:0]       cache_req_addr_o,
   output logic                         cache_req_metadata_v_o,
   output logic [way_w-1:0]             cache_req_way_o,
   input  logic                         cache_req_complete_i,
   input  logic                         data_fill_v_i,
   input  logic [index_w-1:0]           fill_index_i,
   input  logic [way_w-1:0]             fill_way_i,
   input  logic [word_offset_width-1:0] fill_word_i,
   input  logic [instr_width-1:0]       fill_data_i,
   input  logic                         tag_fill_v_i,
   input  logic [tag_w-1:0]             fill_tag_i,
   input  logic                         fill_valid_i,
   output logic                         fill_ready_o);

  logic [way_w-1:0]   repl_way;
  logic               plru_update;
  logic [index_w-1:0] tv_index;
  logic [way_w-1:0]   hit_way;
  logic [ways_p-1:0]  tv_valid_bits;

  icache_array_if #(.sets_p(sets_p), .ways_p(ways_p)) arr_if ();

  icache_pipeline #(.sets_p(sets_p), .ways_p(ways_p)) pipe (
    .clk_i, .reset_i,
    .vaddr_i, .vaddr_v_i, .vaddr_ready_o,
    .ptag_i, .ptag_v_i, .poison_i,
    .data_o, .data_v_o, .miss_o,
    .cache_req_ready_i, .cache_req_complete_i,
    .cache_req_v_o, .cache_req_addr_o,
    .cache_req_metadata_v_o, .cache_req_way_o,
    .fill_ready_o,
    .repl_way_i(repl_way),
    .plru_update_o(plru_update),
    .tv_index_o(tv_index),
    .hit_way_o(hit_way),
    .tv_valid_bits_o(tv_valid_bits),
    .arr(arr_if.pipeline)
  );

  icache_tag_array #(.sets_p(sets_p), .ways_p(ways_p)) tags (
    .clk_i, .reset_i,
    .arr(arr_if.tag),
    .tag_fill_v_i, .fill_index_i, .fill_way_i, .fill_tag_i, .fill_valid_i,
    .fill_ready_i(fill_ready_o)
  );

  icache_data_array #(.sets_p(sets_p), .ways_p(ways_p)) data (
    .clk_i,
    .arr(arr_if.data),
    .data_fill_v_i, .fill_index_i, .fill_way_i, .fill_word_i, .fill_data_i,
    .fill_ready_i(fill_ready_o)
  );

  icache_plru #(.sets_p(sets_p), .ways_p(ways_p)) plru (
    .clk_i, .reset_i,
    .update_i(plru_update),
    .index_i(tv_index),
    .hit_way_i(hit_way),
    .valid_bits_i(tv_valid_bits),
    .repl_way_o(repl_way)
  );

endmodule

// File: tb/tb_icache.sv
// testbench for the VIPT instruction cache
// fixed-seed LCG drives fetches and refills; a reference cache model in here
// predicts every TV result, miss request and replacement way

`timescale 1ns/100ps

module tb_icache
  import icache_pkg::*;
  ();

  localparam int sets    = default_sets;
  localparam int ways    = default_ways;
  localparam int index_w = index_width_f(sets);
  localparam int way_w   = way_width_f(ways);
  localparam int tag_w   = tag_width_f(sets);
  localparam int words   = 2 ** word_offset_width;

  localparam int kind_normal = 0;
  localparam int kind_poison = 1;
  localparam int kind_no_tag = 2;

  logic                         clk_i;
  logic                         reset_i;
  logic [page_offset_width-1:0] vaddr_i;
  logic                         vaddr_v_i;
  logic                         vaddr_ready_o;
  logic [ptag_width-1:0]        ptag_i;
  logic                         ptag_v_i;
  logic                         poison_i;
  logic [instr_width-1:0]       data_o;
  logic                         data_v_o;
  logic                         miss_o;
  logic                         cache_req_ready_i;
  logic                         cache_req_v_o;
  logic [paddr_width-1:0]       cache_req_addr_o;
  logic                         cache_req_metadata_v_o;
  logic [way_w-1:0]             cache_req_way_o;
  logic                         cache_req_complete_i;
  logic                         data_fill_v_i;
  logic [index_w-1:0]           fill_index_i;
  logic [way_w-1:0]             fill_way_i;
  logic [word_offset_width-1:0] fill_word_i;
  logic [instr_width-1:0]       fill_data_i;
  logic                         tag_fill_v_i;
  logic [tag_w-1:0]             fill_tag_i;
  logic                         fill_valid_i;
  logic                         fill_ready_o;

  // reference model state
  logic [tag_w-1:0]       m_tag   [sets][ways];
  logic                   m_valid [sets][ways];
  logic [instr_width-1:0] m_word  [sets][ways][words];
  logic [ways-2:0]        m_tree  [sets];

  // pending fetch stream
  logic [page_offset_width-1:0] s_vaddr [$];
  logic [ptag_width-1:0]        s_ptag  [$];
  int                           s_kind  [$];

  int unsigned rng_state = 58411;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          errors_at_test_start = 0;
  int          exp_meta_way = 0;

  icache_top #(.sets_p(sets), .ways_p(ways)) DUT (
    .clk_i, .reset_i,
    .vaddr_i, .vaddr_v_i, .vaddr_ready_o,
    .ptag_i, .ptag_v_i, .poison_i,
    .data_o, .data_v_o, .miss_o,
    .cache_req_ready_i, .cache_req_v_o, .cache_req_addr_o,
    .cache_req_metadata_v_o, .cache_req_way_o, .cache_req_complete_i,
    .data_fill_v_i, .fill_index_i, .fill_way_i, .fill_word_i, .fill_data_i,
    .tag_fill_v_i, .fill_tag_i, .fill_valid_i, .fill_ready_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic int unsigned next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    // low LCG bits repeat quickly
    return rng_state >> 8;
  endfunction

  function automatic int index_of(input logic [page_offset_width-1:0] vaddr);
    return int'(vaddr[block_offset_width +: index_w]);
  endfunction

  function automatic logic [tag_w-1:0] tag_of(input logic [page_offset_width-1:0] vaddr,
                                              input logic [ptag_width-1:0] ptag);
    logic [paddr_width-1:0] pa;
    pa = {ptag, vaddr};
    return pa[paddr_width-1 -: tag_w];
  endfunction

  function automatic logic [page_offset_width-1:0] word_vaddr(
      input logic [page_offset_width-1:0] base, input int word);
    return {base[page_offset_width-1:block_offset_width], word_offset_width'(word),
            byte_offset_width'(0)};
  endfunction

  // walk from the root, 0 goes left
  function automatic int lru_way_of(input int idx);
    int node;
    int way;
    node = 0;
    way = 0;
    for (int lvl = 0; lvl < way_w; lvl++) begin
      way = 2 * way + int'(m_tree[idx][node]);
      node = 2 * node + 1 + int'(m_tree[idx][node]);
    end
    return way;
  endfunction

  function automatic int victim_way(input int idx);
    for (int w = 0; w < ways; w++) begin
      if (!m_valid[idx][w]) begin
        return w;
      end
    end
    return lru_way_of(idx);
  endfunction

  function automatic void touch_tree(input int idx, input int way);
    int node;
    int dir;
    node = 0;
    for (int lvl = 0; lvl < way_w; lvl++) begin
      dir = (way >> (way_w - 1 - lvl)) & 1;
      m_tree[idx][node] = (dir == 0);
      node = 2 * node + 1 + dir;
    end
  endfunction

  function automatic void reset_model();
    for (int s = 0; s < sets; s++) begin
      m_tree[s] = '0;
      for (int w = 0; w < ways; w++) begin
        m_valid[s][w] = 1'b0;
      end
    end
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_test_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_at_test_start);
    end
    errors_at_test_start = errors;
  endtask

  task automatic add_fetch(input logic [page_offset_width-1:0] vaddr,
                           input logic [ptag_width-1:0] ptag, input int kind);
    s_vaddr.push_back(vaddr);
    s_ptag.push_back(ptag);
    s_kind.push_back(kind);
  endtask

  // compare the TV outputs of one item against the model
  task automatic check_tv(input logic [page_offset_width-1:0] vaddr,
                          input logic [ptag_width-1:0] ptag);
    logic [paddr_width-1:0] pa;
    logic                   hit;
    int                     idx;
    int                     word;
    int                     way;
    pa = {ptag, vaddr};
    idx = index_of(vaddr);
    word = int'(vaddr[byte_offset_width +: word_offset_width]);
    hit = 1'b0;
    way = 0;
    for (int w = ways - 1; w >= 0; w--) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag_of(vaddr, ptag)) begin
        hit = 1'b1;
        way = w;
      end
    end
    check_equal(data_v_o, hit, "data_v_o");
    check_equal(miss_o, !hit, "miss_o");
    if (hit) begin
      check_equal(data_o, m_word[idx][way][word], "data_o");
      touch_tree(idx, way);
    end else if (cache_req_ready_i) begin
      check_equal(cache_req_v_o, 1, "cache_req_v_o");
      check_equal(cache_req_addr_o, pa & ~((1 << block_offset_width) - 1),
                  "cache_req_addr_o");
      check_equal(vaddr_ready_o, 0, "vaddr_ready_o during miss request");
      exp_meta_way = victim_way(idx);
    end
  endtask

  // issue the queued fetches back to back and check each result in TV
  task automatic run_stream();
    int   n;
    int   next;
    int   tl_item;
    int   tv_item;
    int   retired;
    int   cycles;
    logic acc;
    n = s_vaddr.size();
    next = 0;
    tl_item = -1;
    tv_item = -1;
    retired = 0;
    cycles = 0;
    acc = 1'b0;
    while (retired < n && cycles < 4 * n + 20) begin
      @(posedge clk_i);
      cycles++;
      tv_item = -1;
      if (tl_item >= 0) begin
        if (s_kind[tl_item] == kind_normal) begin
          tv_item = tl_item;
        end else begin
          retired++;
        end
      end
      tl_item = acc ? next : -1;
      if (acc) begin
        next++;
      end
      vaddr_v_i <= (next < n);
      if (next < n) begin
        vaddr_i <= s_vaddr[next];
      end
      ptag_v_i <= 1'b0;
      poison_i <= 1'b0;
      if (tl_item >= 0) begin
        ptag_i   <= s_ptag[tl_item];
        ptag_v_i <= (s_kind[tl_item] != kind_no_tag);
        poison_i <= (s_kind[tl_item] == kind_poison);
      end
      @(negedge clk_i);
      acc = vaddr_v_i && vaddr_ready_o;
      if (tv_item >= 0) begin
        check_tv(s_vaddr[tv_item], s_ptag[tv_item]);
        retired++;
      end else begin
        check_equal(data_v_o, 0, "data_v_o with no item in TV");
        check_equal(miss_o, 0, "miss_o with no item in TV");
      end
    end
    assert (retired == n) else begin
      errors++;
      $display("timeout: fetch stream of %0d stalled after %0d results", n, retired);
      @(posedge clk_i);
      vaddr_v_i <= 1'b0;
      ptag_v_i  <= 1'b0;
      poison_i  <= 1'b0;
    end
    s_vaddr.delete();
    s_ptag.delete();
    s_kind.delete();
  endtask

  task automatic check_metadata();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!cache_req_metadata_v_o && cycles < 8);
    assert (cache_req_metadata_v_o) else begin
      errors++;
      $display("timeout: no metadata strobe within %0d cycles of the miss request", cycles);
    end
    if (cache_req_metadata_v_o) begin
      check_equal(cycles, 1, "metadata delay in cycles");
      check_equal(cache_req_way_o, exp_meta_way, "cache_req_way_o");
    end
  endtask

  task automatic pulse_complete();
    int cycles;
    @(posedge clk_i);
    cache_req_complete_i <= 1'b1;
    @(posedge clk_i);
    cache_req_complete_i <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!vaddr_ready_o && cycles < 8);
    assert (vaddr_ready_o) else begin
      errors++;
      $display("timeout: vaddr_ready_o stayed low after the completion pulse");
    end
  endtask

  task automatic write_word(input int idx, input int way, input int word,
                            input logic [instr_width-1:0] value);
    @(posedge clk_i);
    data_fill_v_i <= 1'b1;
    fill_index_i  <= index_w'(idx);
    fill_way_i    <= way_w'(way);
    fill_word_i   <= word_offset_width'(word);
    fill_data_i   <= value;
    @(negedge clk_i);
    check_equal(fill_ready_o, 1, "fill_ready_o with no fetch accepted");
    m_word[idx][way][word] = value;
  endtask

  task automatic write_tag(input logic [page_offset_width-1:0] vaddr,
                           input logic [ptag_width-1:0] ptag, input int way,
                           input logic valid);
    int idx;
    idx = index_of(vaddr);
    @(posedge clk_i);
    data_fill_v_i <= 1'b0;
    tag_fill_v_i  <= 1'b1;
    fill_index_i  <= index_w'(idx);
    fill_way_i    <= way_w'(way);
    fill_tag_i    <= tag_of(vaddr, ptag);
    fill_valid_i  <= valid;
    @(negedge clk_i);
    check_equal(fill_ready_o, 1, "fill_ready_o with no fetch accepted");
    m_valid[idx][way] = valid;
    if (valid) begin
      m_tag[idx][way] = tag_of(vaddr, ptag);
    end
    @(posedge clk_i);
    tag_fill_v_i <= 1'b0;
  endtask

  task automatic fill_block(input logic [page_offset_width-1:0] vaddr,
                            input logic [ptag_width-1:0] ptag, input int way);
    for (int w = 0; w < words; w++) begin
      write_word(index_of(vaddr), way, w, next_random() ^ (rng_state << 24));
    end
    write_tag(vaddr, ptag, way, 1'b1);
  endtask

  initial begin
    int unsigned                  r;
    int                           b;
    int                           n;
    logic [page_offset_width-1:0] base;
    logic [ptag_width-1:0]        blk_ptag [6];
    int                           blk_way  [6];
    reset_i              = 1'b1;
    vaddr_i              = '0;
    vaddr_v_i            = 1'b0;
    ptag_i               = '0;
    ptag_v_i             = 1'b0;
    poison_i             = 1'b0;
    cache_req_ready_i    = 1'b1;
    cache_req_complete_i = 1'b0;
    data_fill_v_i        = 1'b0;
    fill_index_i         = '0;
    fill_way_i           = '0;
    fill_word_i          = '0;
    fill_data_i          = '0;
    tag_fill_v_i         = 1'b0;
    fill_tag_i           = '0;
    fill_valid_i         = 1'b0;
    reset_model();
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;

    // cold miss
    @(negedge clk_i);
    check_equal(data_v_o, 0, "data_v_o after reset");
    check_equal(miss_o, 0, "miss_o after reset");
    check_equal(cache_req_v_o, 0, "cache_req_v_o after reset");
    check_equal(cache_req_metadata_v_o, 0, "cache_req_metadata_v_o after reset");
    r = next_random();
    base = r[page_offset_width-1:0];
    r = next_random();
    blk_ptag[0] = {r[ptag_width-1:4], 4'h0};
    for (int k = 1; k < 6; k++) begin
      blk_ptag[k] = {blk_ptag[0][ptag_width-1:4], 4'(k)};
    end
    add_fetch(base, blk_ptag[0], kind_normal);
    run_stream();
    check_metadata();
    end_test("cold miss");

    // refill the named way, then read every word back to back
    blk_way[0] = exp_meta_way;
    fill_block(base, blk_ptag[0], blk_way[0]);
    pulse_complete();
    for (int w = 0; w < words; w++) begin
      add_fetch(word_vaddr(base, w), blk_ptag[0], kind_normal);
    end
    run_stream();
    end_test("refill then hit");

    // fill the rest of the set, then hit at random and check the LRU victim
    for (int k = 1; k < ways; k++) begin
      add_fetch(word_vaddr(base, next_random() % words), blk_ptag[k], kind_normal);
      run_stream();
      check_metadata();
      check_equal(cache_req_way_o, k, "cache_req_way_o replacement order");
      blk_way[k] = exp_meta_way;
      fill_block(base, blk_ptag[k], blk_way[k]);
      pulse_complete();
    end
    for (int i = 0; i < 12; i++) begin
      r = next_random();
      add_fetch(word_vaddr(base, r % words), blk_ptag[(r >> 8) % ways], kind_normal);
    end
    run_stream();
    add_fetch(base, blk_ptag[4], kind_normal);
    run_stream();
    check_metadata();
    pulse_complete();
    end_test("replacement");

    // a hitting block turns into a miss once its way is invalidated
    b = next_random() % ways;
    add_fetch(base, blk_ptag[b], kind_normal);
    run_stream();
    write_tag(base, blk_ptag[b], blk_way[b], 1'b0);
    add_fetch(base, blk_ptag[b], kind_normal);
    run_stream();
    check_metadata();
    pulse_complete();
    end_test("invalidate");

    // killed items leave no trace, a normal one behind them still hits
    b = (b + 1) % ways;
    add_fetch(word_vaddr(base, 1), blk_ptag[b], kind_poison);
    add_fetch(word_vaddr(base, 2), blk_ptag[b], kind_no_tag);
    add_fetch(word_vaddr(base, 5), blk_ptag[b], kind_normal);
    run_stream();
    end_test("poison and missing tag");

    @(posedge clk_i);
    cache_req_ready_i <= 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_equal(vaddr_ready_o, 0, "vaddr_ready_o with cache_req_ready_i low");
    end
    @(posedge clk_i);
    cache_req_ready_i <= 1'b1;
    add_fetch(word_vaddr(base, 3), blk_ptag[5], kind_normal);
    run_stream();
    check_metadata();
    n = 2 + next_random() % 6;
    repeat (n) begin
      @(negedge clk_i);
      check_equal(vaddr_ready_o, 0, "vaddr_ready_o with a miss outstanding");
    end
    pulse_complete();
    end_test("back-pressure and stall");

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
src/icache_pkg.sv
src/icache_array_if.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_plru.sv
src/icache_pipeline.sv
src/icache_top.sv
tb/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_array_if.sv
  - src/icache_tag_array.sv
  - src/icache_data_array.sv
  - src/icache_plru.sv
  - src/icache_pipeline.sv
  - src/icache_top.sv
  - target: test
    files:
      - tb/tb_icache.sv
